// ==== hdl/xc_pkg.sv ====
// Shared sizes, opcodes, frame layout and serial timing, referenced by scope from RTL and testbench
package xc_pkg;

    // Input lines and unordered line pairs
    localparam int NUM_LINES = 4;
    localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;

    // Counter width, wraps on overflow
    localparam int RESOLUTION = 16;
    localparam int COUNT_BYTES = RESOLUTION / 8;
    typedef logic [RESOLUTION-1:0] count_t;

    // Frame layout: header, counts, autos, crosses
    localparam int NUM_WORDS = 2 * NUM_LINES + NUM_PAIRS;
    localparam int FRAME_BYTES = 1 + NUM_WORDS * COUNT_BYTES;
    localparam int IDX_W = $clog2(FRAME_BYTES);
    typedef logic [IDX_W-1:0] idx_t;
    localparam logic [7:0] FRAME_HEADER = 8'hA5;

    // Serial bit period in clock cycles
    localparam int BAUD_DIV = 8;
    localparam int BAUD_W = $clog2(BAUD_DIV);
    typedef logic [BAUD_W-1:0] baud_t;

    // Command opcodes in the upper nibble
    localparam logic [3:0] OP_LAG = 4'h1;
    localparam logic [3:0] OP_WIN = 4'h2;
    localparam logic [3:0] OP_RUN = 4'h3;

    // Auto-correlation lag range
    localparam int MAX_LAG = 15;
    localparam int LAG_W = 4;
    typedef logic [LAG_W-1:0] lag_t;

    // Window length is 2 ** (WIN_BASE_LOG + argument)
    localparam int WIN_BASE_LOG = 4;
    localparam int MAX_WIN_ARG = 7;
    localparam int WARG_W = 3;
    typedef logic [WARG_W-1:0] warg_t;
    localparam warg_t DEFAULT_WIN_ARG = 3'd2;

    // Wide enough for the longest window
    localparam int WIN_W = WIN_BASE_LOG + MAX_WIN_ARG + 1;
    typedef logic [WIN_W-1:0] win_t;

endpackage

// ==== hdl/uart_rx.sv ====
// Serial 8N1 receiver for the command line, pulses a strobe for every well-framed byte
module uart_rx (
    input  logic       clki,
    input  logic       arst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t        state;
    logic          rx_m;
    logic          rx_s;
    xc_pkg::baud_t baud_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift;

    // Two-stage synchronizer, line idles high
    always_ff @(posedge clki or negedge arst_n) begin
        if (!arst_n) begin
            rx_m <= 1'b1;
            rx_s <= 1'b1;
        end else begin
            rx_m <= rx;
            rx_s <= rx_m;
        end
    end

    always_ff @(posedge clki or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            baud_cnt  <= baud_cnt + xc_pkg::baud_t'(1);
            case (state)
                S_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_s) state <= S_START;
                end
                // Recheck start bit at its middle, glitches go back to idle
                S_START: begin
                    if (baud_cnt == xc_pkg::baud_t'(xc_pkg::BAUD_DIV / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s ? S_IDLE : S_DATA;
                    end
                end
                // From here every sample lands mid-bit
                S_DATA: begin
                    if (baud_cnt == xc_pkg::baud_t'(xc_pkg::BAUD_DIV - 1)) begin
                        if (bit_cnt == 3'd7) state <= S_STOP;
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
                // Stop bit must be high or the byte is dropped
                default: begin
                    if (baud_cnt == xc_pkg::baud_t'(xc_pkg::BAUD_DIV - 1)) begin
                        state     <= S_IDLE;
                        rx_strobe <= rx_s;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clki) begin
        if (state == S_DATA && baud_cnt == xc_pkg::baud_t'(xc_pkg::BAUD_DIV - 1))
            shift <= {rx_s, shift[7:1]};
        if (state == S_STOP) rx_data <= shift;
    end

endmodule

// ==== hdl/cmd_decode.sv ====
// Command decoder, turns received bytes into lag and window settings and a run pulse
module cmd_decode (
    input  logic              clki,
    input  logic              arst_n,
    input  logic [7:0]        rx_data,
    input  logic              rx_strobe,
    input  logic              busy,
    output xc_pkg::lag_t      lag,
    output xc_pkg::win_t      win_len,
    output logic              run
);

    logic [3:0]    op;
    logic [3:0]    arg;
    xc_pkg::warg_t win_arg;

    // Opcode in upper nibble, argument in lower
    assign op  = rx_data[7:4];
    assign arg = rx_data[3:0];

    always_ff @(posedge clki or negedge arst_n) begin
        if (!arst_n) begin
            lag     <= '0;
            win_arg <= xc_pkg::DEFAULT_WIN_ARG;
            run     <= 1'b0;
        end else begin
            run <= 1'b0;
            if (rx_strobe) begin
                case (op)
                    xc_pkg::OP_LAG: begin
                        lag <= (int'(arg) > xc_pkg::MAX_LAG) ?
                            xc_pkg::lag_t'(xc_pkg::MAX_LAG) : arg;
                    end
                    // Exponent argument clamps at the top
                    xc_pkg::OP_WIN: begin
                        win_arg <= (int'(arg) > xc_pkg::MAX_WIN_ARG) ?
                            xc_pkg::warg_t'(xc_pkg::MAX_WIN_ARG) : arg[2:0];
                    end
                    // Dropped while a window or frame is in flight
                    xc_pkg::OP_RUN: run <= !busy;
                    default: ;
                endcase
            end
        end
    end

    // Window length in cycles
    assign win_len = xc_pkg::win_t'(1) << (xc_pkg::WIN_BASE_LOG + int'(win_arg));

    // Run never coincides with an open window or a frame still in flight
    a_run_idle: assert property (@(posedge clki) disable iff (!arst_n) run |-> !busy);

endmodule

// ==== hdl/correlator.sv ====
// Execute stage, keeps lag history, times the integration window and updates all counters
module correlator (
    input  logic                                    clki,
    input  logic                                    arst_n,
    input  logic [xc_pkg::NUM_LINES-1:0]            line_in,
    input  xc_pkg::lag_t                            lag,
    input  xc_pkg::win_t                            win_len,
    input  logic                                    run,
    output logic                                    integrating,
    output logic                                    done,
    output xc_pkg::count_t [xc_pkg::NUM_LINES-1:0]  count,
    output xc_pkg::count_t [xc_pkg::NUM_LINES-1:0]  auto,
    output xc_pkg::count_t [xc_pkg::NUM_PAIRS-1:0]  cross_cnt
);

    xc_pkg::win_t                 win_cnt;
    logic                         start;
    logic [xc_pkg::NUM_LINES-1:0] tap;

    // Accepted run, clears counters for the new window
    assign start = run && !integrating;

    // Window down-counter, done lands on the first cycle after the last edge
    always_ff @(posedge clki or negedge arst_n) begin
        if (!arst_n) begin
            integrating <= 1'b0;
            done        <= 1'b0;
            win_cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                integrating <= 1'b1;
                win_cnt     <= win_len;
            end else if (integrating) begin
                win_cnt <= win_cnt - xc_pkg::win_t'(1);
                if (win_cnt == xc_pkg::win_t'(1)) begin
                    integrating <= 1'b0;
                    done        <= 1'b1;
                end
            end
        end
    end

    for (genvar i = 0; i < xc_pkg::NUM_LINES; i++) begin : g_line
        logic [xc_pkg::MAX_LAG-1:0] hist;
        logic [xc_pkg::MAX_LAG:0]   taps;

        // Tap 0 is the current sample, tap n is n edges back
        assign taps   = {hist, line_in[i]};
        assign tap[i] = taps[lag];

        // History runs all the time so lags reach before the window
        always_ff @(posedge clki) begin
            hist <= {hist[xc_pkg::MAX_LAG-2:0], line_in[i]};
        end

        always_ff @(posedge clki) begin
            if (start) begin
                count[i] <= '0;
                auto[i]  <= '0;
            end else if (integrating) begin
                if (line_in[i]) count[i] <= count[i] + xc_pkg::count_t'(1);
                if (line_in[i] && tap[i]) auto[i] <= auto[i] + xc_pkg::count_t'(1);
            end
        end
    end

    // Pair index in (0,1),(0,2),...,(2,3) order
    for (genvar a = 0; a < xc_pkg::NUM_LINES; a++) begin : g_a
        for (genvar b = a + 1; b < xc_pkg::NUM_LINES; b++) begin : g_b
            localparam int P = a * xc_pkg::NUM_LINES - a * (a + 1) / 2 + b - a - 1;

            always_ff @(posedge clki) begin
                if (start)
                    cross_cnt[P] <= '0;
                else if (integrating && line_in[a] && line_in[b])
                    cross_cnt[P] <= cross_cnt[P] + xc_pkg::count_t'(1);
            end
        end
    end

    // Decode holds back run for the whole window
    a_no_run_open: assert property (@(posedge clki) disable iff (!arst_n)
        run |-> !integrating);

    // One done per window
    a_done_pulse: assert property (@(posedge clki) disable iff (!arst_n)
        done |=> !done);

endmodule

// ==== hdl/frame_packer.sv ====
// Result stage, walks header and counters into a byte stream for the serial transmitter
module frame_packer (
    input  logic                                    clki,
    input  logic                                    arst_n,
    input  logic                                    done,
    input  xc_pkg::count_t [xc_pkg::NUM_LINES-1:0]  count,
    input  xc_pkg::count_t [xc_pkg::NUM_LINES-1:0]  auto,
    input  xc_pkg::count_t [xc_pkg::NUM_PAIRS-1:0]  cross_cnt,
    input  logic                                    tx_busy,
    output logic [7:0]                              tx_data,
    output logic                                    tx_start,
    output logic                                    sending
);

    typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT} state_t;

    state_t         state;
    xc_pkg::idx_t   idx;
    xc_pkg::count_t words [xc_pkg::NUM_WORDS];
    xc_pkg::count_t word;
    int             k;

    // Counters in frame order
    always_comb begin
        for (int i = 0; i < xc_pkg::NUM_LINES; i++) begin
            words[i]                     = count[i];
            words[xc_pkg::NUM_LINES + i] = auto[i];
        end
        for (int p = 0; p < xc_pkg::NUM_PAIRS; p++)
            words[2 * xc_pkg::NUM_LINES + p] = cross_cnt[p];
    end

    // Byte 0 is the header, then each counter MSB first
    always_comb begin
        k       = int'(idx) - 1;
        word    = '0;
        tx_data = xc_pkg::FRAME_HEADER;
        if (idx != '0) begin
            word    = words[k / xc_pkg::COUNT_BYTES];
            tx_data = word[8 * (xc_pkg::COUNT_BYTES - 1 - k % xc_pkg::COUNT_BYTES) +: 8];
        end
    end

    // Issue only into an idle transmitter
    assign tx_start = (state == S_SEND) && !tx_busy;
    // Covers the done cycle so busy has no gap
    assign sending  = done || (state != S_IDLE);

    always_ff @(posedge clki or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    idx <= '0;
                    if (done) state <= S_SEND;
                end
                S_SEND: begin
                    if (!tx_busy) state <= S_WAIT;
                end
                // Busy is already up on the first wait cycle
                default: begin
                    if (!tx_busy) begin
                        if (idx == xc_pkg::idx_t'(xc_pkg::FRAME_BYTES - 1)) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + xc_pkg::idx_t'(1);
                            state <= S_SEND;
                        end
                    end
                end
            endcase
        end
    end

    // Transmitter is free at start and takes the byte on the next edge
    a_start_free: assert property (@(posedge clki) disable iff (!arst_n)
        tx_start |-> !tx_busy ##1 tx_busy);

endmodule

// ==== hdl/uart_tx.sv ====
// Serial 8N1 transmitter for the result line, busy from start request to end of stop bit
module uart_tx (
    input  logic       clki,
    input  logic       arst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);

    xc_pkg::baud_t baud_cnt;
    logic [3:0]    bit_cnt;
    logic [8:0]    shift;
    logic          bit_end;

    assign bit_end = (baud_cnt == xc_pkg::baud_t'(xc_pkg::BAUD_DIV - 1));

    // Bit 0 start, 1 to 8 data, 9 stop
    always_ff @(posedge clki or negedge arst_n) begin
        if (!arst_n) begin
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx       <= 1'b0;
                tx_busy  <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
                tx      <= 1'b1;
            end else begin
                tx      <= shift[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + xc_pkg::baud_t'(1);
        end
    end

    // Data LSB first with the stop bit behind it
    always_ff @(posedge clki) begin
        if (!tx_busy && tx_start)
            shift <= {1'b1, tx_data};
        else if (tx_busy && bit_end && bit_cnt != 4'd9)
            shift <= {1'b1, shift[8:1]};
    end

endmodule

// ==== hdl/xc_main.sv ====
// Correlator top level, serial command in, serial frame out, sampled input lines
module xc_main (
    input  logic                         clki,
    input  logic                         arst_n,
    input  logic                         rx,
    output logic                         tx,
    input  logic [xc_pkg::NUM_LINES-1:0] line_in,
    output logic                         integrating
);

    logic [7:0]                             rx_data;
    logic                                   rx_strobe;
    xc_pkg::lag_t                           lag;
    xc_pkg::win_t                           win_len;
    logic                                   run;
    logic                                   done;
    xc_pkg::count_t [xc_pkg::NUM_LINES-1:0] count;
    xc_pkg::count_t [xc_pkg::NUM_LINES-1:0] auto;
    xc_pkg::count_t [xc_pkg::NUM_PAIRS-1:0] cross_cnt;
    logic [7:0]                             tx_data;
    logic                                   tx_start;
    logic                                   tx_busy;
    logic                                   sending;
    logic                                   busy;

    // Window open or frame still going out
    assign busy = integrating | sending;

    uart_rx u_rx (
        .clki, .arst_n, .rx, .rx_data, .rx_strobe
    );

    // Decode
    cmd_decode u_decode (
        .clki, .arst_n, .rx_data, .rx_strobe, .busy, .lag, .win_len, .run
    );

    // Execute
    correlator u_corr (
        .clki, .arst_n, .line_in, .lag, .win_len, .run,
        .integrating, .done, .count, .auto, .cross_cnt
    );

    // Result
    frame_packer u_pack (
        .clki, .arst_n, .done, .count, .auto, .cross_cnt,
        .tx_busy, .tx_data, .tx_start, .sending
    );

    uart_tx u_tx (
        .clki, .arst_n, .tx_data, .tx_start, .tx, .tx_busy
    );

endmodule

// ==== test/xc_tb.sv ====
// Testbench for xc_main that drives commands and random lines and checks every frame against a model
module xc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                         clki;
    logic                         arst_n;
    logic                         rx;
    logic                         tx;
    logic [xc_pkg::NUM_LINES-1:0] line_in;
    logic                         integrating;

    logic [xc_pkg::NUM_LINES-1:0] line_mask;
    logic [31:0]                  rnd_state;
    logic [xc_pkg::NUM_LINES-1:0] hist [$];
    logic [7:0]                   rxq [$];
    xc_pkg::count_t               last_auto [xc_pkg::NUM_LINES];
    xc_pkg::count_t               last_cross [xc_pkg::NUM_PAIRS];
    int  cur_lag;
    int  win_first;
    int  win_last;
    int  win_edges;
    logic int_prev;
    int  frames;
    int  err_value;
    int  err_other;
    logic rx_active;
    int  rcnt;
    logic [7:0] rbyte;

    xc_main uut (
        .clki, .arst_n, .rx, .tx, .line_in, .integrating
    );

    initial begin
        clki = 1'b0;
        forever #5 clki = ~clki;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected counter from the recorded history
    // Kind 0 is count, 1 is auto, 2 is cross of lines a and b
    function automatic xc_pkg::count_t ref_word(input int kind, input int a, input int b);
        xc_pkg::count_t acc;
        logic           past;
        acc = '0;
        for (int j = win_first; j <= win_last; j++) begin
            past = (j - cur_lag >= 0) ? hist[j - cur_lag][a] : 1'b0;
            if (kind == 0 && hist[j][a])
                acc = acc + xc_pkg::count_t'(1);
            else if (kind == 1 && hist[j][a] && past)
                acc = acc + xc_pkg::count_t'(1);
            else if (kind == 2 && hist[j][a] && hist[j][b])
                acc = acc + xc_pkg::count_t'(1);
        end
        return acc;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input xc_pkg::count_t got,
                               input xc_pkg::count_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_cross(input string name, input xc_pkg::count_t got,
                               input xc_pkg::count_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_window(input string name, input xc_pkg::win_t got,
                                input xc_pkg::win_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Random line patterns restricted by the mask
    always @(posedge clki) begin
        rnd_state = xorshift(rnd_state);
        line_in <= rnd_state[xc_pkg::NUM_LINES-1:0] & line_mask;
    end

    // History of every edge and the edges inside the window
    always @(posedge clki) begin
        hist.push_back(line_in);
        if (integrating) begin
            if (!int_prev) begin
                win_first = hist.size() - 1;
                win_edges = 0;
            end
            win_last = hist.size() - 1;
            win_edges++;
        end
        int_prev = integrating;
    end

    // Serial receiver sampling tx mid-bit
    always @(posedge clki) begin
        if (!rx_active) begin
            if (!tx && arst_n) begin
                rx_active = 1'b1;
                rcnt = 0;
            end
        end else begin
            rcnt++;
            if (rcnt % xc_pkg::BAUD_DIV == xc_pkg::BAUD_DIV / 2) begin
                if (rcnt / xc_pkg::BAUD_DIV == 0) begin
                    // Start bit must still be low at its middle
                    if (tx) begin
                        err_other++;
                        $display("Start bit on tx did not hold low at %0t", $time);
                        rx_active = 1'b0;
                    end
                end else if (rcnt / xc_pkg::BAUD_DIV <= 8) begin
                    rbyte[rcnt / xc_pkg::BAUD_DIV - 1] = tx;
                end else begin
                    if (!tx) begin
                        err_other++;
                        $display("Stop bit on tx was low at %0t", $time);
                    end
                    rxq.push_back(rbyte);
                    rx_active = 1'b0;
                end
            end
        end
    end

    // Compare process checks each complete frame against the model
    always @(negedge clki) begin : compare
        logic [7:0]     b;
        xc_pkg::count_t w [xc_pkg::NUM_WORDS];
        int             p;
        if (rxq.size() >= xc_pkg::FRAME_BYTES) begin
            b = rxq.pop_front();
            check_byte("header", b, xc_pkg::FRAME_HEADER);
            for (int i = 0; i < xc_pkg::NUM_WORDS; i++) begin
                w[i] = '0;
                for (int k = 0; k < xc_pkg::COUNT_BYTES; k++)
                    w[i] = {w[i][xc_pkg::RESOLUTION-9:0], rxq.pop_front()};
            end
            for (int i = 0; i < xc_pkg::NUM_LINES; i++) begin
                last_auto[i] = w[xc_pkg::NUM_LINES + i];
                check_count($sformatf("count[%0d]", i), w[i], ref_word(0, i, 0));
                check_count($sformatf("auto[%0d]", i), last_auto[i], ref_word(1, i, 0));
            end
            p = 0;
            for (int a = 0; a < xc_pkg::NUM_LINES; a++) begin
                for (int c = a + 1; c < xc_pkg::NUM_LINES; c++) begin
                    last_cross[p] = w[2 * xc_pkg::NUM_LINES + p];
                    check_cross($sformatf("cross[%0d%0d]", a, c), last_cross[p],
                                ref_word(2, a, c));
                    p++;
                end
            end
            frames++;
        end
    end

    // Sends one 8N1 byte on rx followed by one idle bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int n = 0; n < 11; n++) begin
            @(posedge clki);
            rx <= (n < 10) ? bits[n] : 1'b1;
            repeat (xc_pkg::BAUD_DIV - 1) @(posedge clki);
        end
    endtask

    task automatic wait_frame(input int n0);
        int t;
        t = 0;
        while (frames == n0 && t < 20000) begin
            @(negedge clki);
            t++;
        end
        if (frames == n0) begin
            err_other++;
            $display("No frame arrived within 20000 cycles at %0t", $time);
        end
    endtask

    // Sends RUN and checks the frame and the window length
    task automatic run_frame(input int arg);
        int n0;
        n0 = frames;
        send_byte({xc_pkg::OP_RUN, 4'h0});
        wait_frame(n0);
        check_window("window edges", xc_pkg::win_t'(win_edges),
                     xc_pkg::win_t'(2 ** (xc_pkg::WIN_BASE_LOG + arg)));
    endtask

    initial begin : main
        int t;
        int n0;
        rx = 1'b1;
        line_in = '0;
        line_mask = '1;
        rnd_state = 32'd41;
        arst_n = 1'b0;
        cur_lag = 0;
        win_first = 0;
        win_last = -1;
        win_edges = 0;
        int_prev = 1'b0;
        frames = 0;
        err_value = 0;
        err_other = 0;
        rx_active = 1'b0;
        repeat (16) @(posedge clki);
        arst_n <= 1'b1;
        repeat (20) @(posedge clki);

        // Default window with lag 0
        run_frame(xc_pkg::DEFAULT_WIN_ARG);
        for (int i = 0; i < xc_pkg::NUM_LINES; i++)
            check_count($sformatf("auto equals count[%0d]", i), last_auto[i],
                        ref_word(0, i, 0));

        // Lags that reach back before the window
        send_byte({xc_pkg::OP_LAG, 4'd3});
        cur_lag = 3;
        run_frame(xc_pkg::DEFAULT_WIN_ARG);
        send_byte({xc_pkg::OP_LAG, 4'd15});
        cur_lag = 15;
        run_frame(xc_pkg::DEFAULT_WIN_ARG);

        // Only line 2 active so no pair can coincide
        line_mask = 4'b0100;
        run_frame(xc_pkg::DEFAULT_WIN_ARG);
        for (int p = 0; p < xc_pkg::NUM_PAIRS; p++)
            check_cross($sformatf("single line cross[%0d]", p), last_cross[p], '0);
        line_mask = '1;

        // Shortest and a long window
        send_byte({xc_pkg::OP_WIN, 4'd0});
        run_frame(0);
        send_byte({xc_pkg::OP_WIN, 4'd5});
        run_frame(5);
        send_byte({xc_pkg::OP_WIN, 4'd0});

        // RUN while the frame is going out is dropped
        n0 = frames;
        send_byte({xc_pkg::OP_RUN, 4'h0});
        t = 0;
        while (rxq.size() == 0 && t < 5000) begin
            @(negedge clki);
            t++;
        end
        if (rxq.size() == 0) begin
            err_other++;
            $display("Frame transmission did not start within 5000 cycles");
        end
        send_byte({xc_pkg::OP_RUN, 4'h0});
        wait_frame(n0);
        t = 0;
        while (rxq.size() == 0 && t < 4000) begin
            @(negedge clki);
            t++;
        end
        if (rxq.size() != 0 || frames != n0 + 1) begin
            err_other++;
            $display("A RUN sent during a frame produced a second frame");
        end

        // Unknown opcode leaves lag and window alone
        send_byte(8'h75);
        run_frame(0);

        $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/xc_pkg.sv
hdl/uart_rx.sv
hdl/cmd_decode.sv
hdl/correlator.sv
hdl/frame_packer.sv
hdl/uart_tx.sv
hdl/xc_main.sv
test/xc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module xc_tb -f all.f -o xc_sim

./obj_dir/xc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
